// ==== source/pipePkg.sv ====
// rvPipe shared definitions
// Sizes, opcode and ALU encodings, control bundle and stage payloads
package pipePkg;

    localparam int xlen      = 32;
    localparam int resetPc   = 0;
    localparam int dataWords = 256;
    localparam int dataIdxW  = $clog2(dataWords);  // Word index width

    // RV32I major opcodes used by the core
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB  // lui
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;  // Operand B from imm32
        logic  branch;
        aluOpE aluOp;
    } ctrlSigT;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } ifIdT;

    typedef struct packed {
        ctrlSigT         ctrl;
        logic [xlen-1:0] pc;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] rData1;
        logic [xlen-1:0] rData2;
        logic [xlen-1:0] imm32;
    } idExT;

    typedef struct packed {
        ctrlSigT         ctrl;
        logic [4:0]      rd;
        logic [xlen-1:0] aluResult;  // Also the memory address
        logic [xlen-1:0] storeData;
    } exMemT;

    typedef struct packed {
        ctrlSigT         ctrl;
        logic [4:0]      rd;
        logic [xlen-1:0] aluResult;
        logic [xlen-1:0] loadData;
    } memWbT;

endpackage

// ==== source/pipeRegs.sv ====
// rvPipe pipeline registers
// IF/ID with stall hold and flush, ID/EX with bubble insert,
// EX/MEM and MEM/WB as plain stage registers

module ifIdReg import pipePkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            flush,
    input  logic [xlen-1:0] inPc,
    input  logic [xlen-1:0] inInst,
    output ifIdT            out
);

    // Flush wins over stall, a taken branch must drop the held slot
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out.valid <= 1'b0;
        end else if (!stall) begin
            out.valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out.pc   <= inPc;
            out.inst <= inInst;
        end
    end

endmodule

module idExReg import pipePkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic bubble,
    input  idExT in,
    output idExT out
);

    always_ff @(posedge clk) begin
        if (rst || bubble) begin
            out.ctrl <= '0;  // Turns the slot into a nop
        end else begin
            out.ctrl <= in.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        out.pc     <= in.pc;
        out.rs1    <= in.rs1;
        out.rs2    <= in.rs2;
        out.rd     <= in.rd;
        out.rData1 <= in.rData1;
        out.rData2 <= in.rData2;
        out.imm32  <= in.imm32;
    end

endmodule

module exMemReg import pipePkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  exMemT in,
    output exMemT out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out.ctrl <= '0;
        end else begin
            out.ctrl <= in.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        out.rd        <= in.rd;
        out.aluResult <= in.aluResult;
        out.storeData <= in.storeData;
    end

endmodule

module memWbReg import pipePkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  memWbT in,
    output memWbT out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out.ctrl <= '0;
        end else begin
            out.ctrl <= in.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        out.rd        <= in.rd;
        out.aluResult <= in.aluResult;
        out.loadData  <= in.loadData;
    end

endmodule

// ==== source/decodeStage.sv ====
// rvPipe decode stage
// Control decode, immediate build, register file with write-first
// bypass and load-use hazard detection
module decodeStage import pipePkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  ifIdT  ifId,
    input  idExT  exStage,   // Instruction now in EX
    input  memWbT wb,
    output idExT  idEx,
    output logic  stall
);

    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] inst;
    logic [xlen-1:0] wbValue;
    logic            wbWrite;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    ctrlSigT         ctrl;
    logic            useRs1;
    logic            useRs2;

    assign inst = ifId.inst;
    assign rs1  = inst[19:15];
    assign rs2  = inst[24:20];

    assign wbValue = wb.ctrl.memToReg ? wb.loadData : wb.aluResult;
    assign wbWrite = wb.ctrl.regWrite && (wb.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite) begin
            regs[wb.rd] <= wbValue;
        end
    end

    always_comb begin
        ctrl   = '0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        case (opcodeE'(inst[6:0]))
            opReg: begin
                ctrl.regWrite = 1'b1;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
                case (inst[14:12])
                    3'b000:  ctrl.aluOp = inst[30] ? aluSub : aluAdd;
                    3'b010:  ctrl.aluOp = aluSlt;
                    3'b100:  ctrl.aluOp = aluXor;
                    3'b110:  ctrl.aluOp = aluOr;
                    3'b111:  ctrl.aluOp = aluAnd;
                    default: ctrl.aluOp = aluAdd;
                endcase
            end
            opImm: begin  // addi only
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluAdd;
                useRs1 = 1'b1;
            end
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPassB;
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluAdd;
                useRs1 = 1'b1;
            end
            opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluAdd;
                useRs1 = 1'b1;
                useRs2 = 1'b1;  // Store data
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
                useRs1 = 1'b1;
                useRs2 = 1'b1;
            end
            default: ctrl = '0;
        endcase
        if (!ifId.valid) begin
            ctrl = '0;
        end
    end

    always_comb begin
        idEx.ctrl = ctrl;
        idEx.pc   = ifId.pc;
        idEx.rs1  = rs1;
        idEx.rs2  = rs2;
        idEx.rd   = inst[11:7];
        // Write-first, a same-cycle writeback is seen here
        idEx.rData1 = (rs1 == 5'd0) ? '0 : (wbWrite && wb.rd == rs1) ? wbValue : regs[rs1];
        idEx.rData2 = (rs2 == 5'd0) ? '0 : (wbWrite && wb.rd == rs2) ? wbValue : regs[rs2];
        case (opcodeE'(inst[6:0]))
            opStore:  idEx.imm32 = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            opBranch: idEx.imm32 = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
            opLui:    idEx.imm32 = {inst[31:12], 12'b0};
            default:  idEx.imm32 = {{20{inst[31]}}, inst[31:20]};  // I format
        endcase
    end

    // Load in EX whose result the decoding instruction needs
    assign stall = exStage.ctrl.memRead && (exStage.rd != 5'd0) &&
                   ((useRs1 && exStage.rd == rs1) || (useRs2 && exStage.rd == rs2));

endmodule

// ==== source/executeStage.sv ====
// rvPipe execute stage
// Operand forwarding, ALU and beq resolution
module executeStage import pipePkg::*; (
    input  idExT            idEx,
    input  exMemT           exMem,
    input  logic [xlen-1:0] wbData,
    input  memWbT           wb,
    output exMemT           exOut,
    output logic            branchTaken,
    output logic [xlen-1:0] branchTarget
);

    logic [xlen-1:0] fwdA;
    logic [xlen-1:0] fwdB;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;

    // EX/MEM first, then MEM/WB, then the value read in decode
    function automatic logic [xlen-1:0] fwdSel(input logic [4:0] rs,
                                               input logic [xlen-1:0] regData);
        logic [xlen-1:0] val;
        val = regData;
        if (exMem.ctrl.regWrite && !exMem.ctrl.memToReg &&
            exMem.rd != 5'd0 && exMem.rd == rs) begin
            val = exMem.aluResult;
        end else if (wb.ctrl.regWrite && wb.rd != 5'd0 && wb.rd == rs) begin
            val = wbData;
        end
        return val;
    endfunction

    always_comb begin
        fwdA = fwdSel(idEx.rs1, idEx.rData1);
        fwdB = fwdSel(idEx.rs2, idEx.rData2);
    end

    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm32 : fwdB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:   aluResult = fwdA + opB;
            aluSub:   aluResult = fwdA - opB;
            aluAnd:   aluResult = fwdA & opB;
            aluOr:    aluResult = fwdA | opB;
            aluXor:   aluResult = fwdA ^ opB;
            aluSlt:   aluResult = {{(xlen-1){1'b0}}, $signed(fwdA) < $signed(opB)};
            aluPassB: aluResult = opB;
            default:  aluResult = fwdA + opB;
        endcase
    end

    always_comb begin
        exOut.ctrl      = idEx.ctrl;
        exOut.rd        = idEx.rd;
        exOut.aluResult = aluResult;
        exOut.storeData = fwdB;  // sw source, never the immediate
    end

    assign branchTaken  = idEx.ctrl.branch && (fwdA == fwdB);
    assign branchTarget = idEx.pc + idEx.imm32;

endmodule

// ==== source/dataMemory.sv ====
// rvPipe data memory
// Word array, write at the end of MEM, combinational read
module dataMemory import pipePkg::*; (
    input  logic            clk,
    input  exMemT           exMem,
    output logic [xlen-1:0] loadData
);

    logic [xlen-1:0]     mem [dataWords];
    logic [dataIdxW-1:0] wordIdx;

    assign wordIdx = exMem.aluResult[dataIdxW+1:2];  // Byte address to word

    always_ff @(posedge clk) begin
        if (exMem.ctrl.memWrite) begin
            mem[wordIdx] <= exMem.storeData;
        end
    end

    assign loadData = mem[wordIdx];

endmodule

// ==== source/pipeCore.sv ====
// rvPipe core top
// PC and next-PC select, stage wiring and writeback report
module pipeCore import pipePkg::*; (
    input  logic            clk,
    input  logic            rst,
    output logic [xlen-1:0] instAddr,
    input  logic [xlen-1:0] instData,
    output logic            wbValid,
    output logic [4:0]      wbRd,
    output logic [xlen-1:0] wbData
);

    logic [xlen-1:0] pc;
    logic            stall;
    logic            branchTaken;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] loadData;
    ifIdT            ifId;
    idExT            idExNext;
    idExT            idEx;
    exMemT           exMemNext;
    exMemT           exMem;
    memWbT           memWbNext;
    memWbT           memWb;

    // Branch redirect has priority, a load in EX is never a branch
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= xlen'(resetPc);
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign instAddr = pc;

    ifIdReg ifIdRegI (.clk(clk), .rst(rst), .stall(stall), .flush(branchTaken),
                      .inPc(pc), .inInst(instData), .out(ifId));

    decodeStage decodeStageI (.clk(clk), .rst(rst), .ifId(ifId), .exStage(idEx),
                              .wb(memWb), .idEx(idExNext), .stall(stall));

    idExReg idExRegI (.clk(clk), .rst(rst), .bubble(stall || branchTaken),
                      .in(idExNext), .out(idEx));

    executeStage executeStageI (.idEx(idEx), .exMem(exMem), .wbData(wbData), .wb(memWb),
                                .exOut(exMemNext), .branchTaken(branchTaken),
                                .branchTarget(branchTarget));

    exMemReg exMemRegI (.clk(clk), .rst(rst), .in(exMemNext), .out(exMem));

    dataMemory dataMemoryI (.clk(clk), .exMem(exMem), .loadData(loadData));

    always_comb begin
        memWbNext.ctrl      = exMem.ctrl;
        memWbNext.rd        = exMem.rd;
        memWbNext.aluResult = exMem.aluResult;
        memWbNext.loadData  = loadData;
    end

    memWbReg memWbRegI (.clk(clk), .rst(rst), .in(memWbNext), .out(memWb));

    assign wbData  = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluResult;
    assign wbRd    = memWb.rd;
    assign wbValid = memWb.ctrl.regWrite && (memWb.rd != 5'd0);  // x0 writes stay silent

endmodule

// ==== testbench/pipeCore_checker.sv ====
// rvPipe control checks
// Reset, branch redirect, stall length and stall behavior of the core
module pipeCoreChecker import pipePkg::*; (
    input logic            clk,
    input logic            rst,
    input logic            stall,
    input logic            branchTaken,
    input logic [xlen-1:0] pc,
    input logic [xlen-1:0] branchTarget,
    input logic            wbValid
);

    timeunit 1ns;
    timeprecision 1ps;

    // MEM/WB holds a bubble right after reset
    resetQuiet: assert property (@(posedge clk) rst |=> !wbValid)
        else $error("wbValid high in the cycle after reset");

    // The redirect must land even if decode is stalling
    branchRedirect: assert property (@(posedge clk) disable iff (rst)
        branchTaken |=> pc == $past(branchTarget))
        else $error("Taken branch did not load its target into the PC");

    // One bubble per load-use hazard
    stallOnce: assert property (@(posedge clk) disable iff (rst)
        stall |=> !stall)
        else $error("Load-use stall lasted more than one cycle");

    stallHold: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(pc))  // Load-use stall freezes fetch
        else $error("PC moved during a load-use stall");

endmodule

// ==== testbench/pipeCore_tb.sv ====
// rvPipe core testbench
// Serves the program from a ROM and checks every retirement against
// the expected records in the test data file
module pipeCoreTb import pipePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic            clk;
    logic            rst;
    logic [xlen-1:0] instAddr;
    logic [xlen-1:0] instData;
    logic            wbValid;
    logic [4:0]      wbRd;
    logic [xlen-1:0] wbData;

    logic [31:0]     testData [128];  // Program words, then expected records
    int              progLen;
    int              retireCount;
    int              checkedCount;
    int              recordIdx;
    logic [4:0]      expRd;
    logic [xlen-1:0] expData;

    pipeCore pipeCore_i (
        .clk(clk),
        .rst(rst),
        .instAddr(instAddr),
        .instData(instData),
        .wbValid(wbValid),
        .wbRd(wbRd),
        .wbData(wbData)
    );

    bind pipeCore pipeCoreChecker checkerI (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .branchTaken(branchTaken),
        .pc(pc),
        .branchTarget(branchTarget),
        .wbValid(wbValid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Instruction ROM, nop past the end of the program
    always_comb begin
        int wordIdx;
        wordIdx = int'(instAddr[31:2]);
        if (wordIdx >= 0 && wordIdx < progLen) begin
            instData = testData[wordIdx + 1];
        end else begin
            instData = 32'h0000_0013;  // addi x0, x0, 0
        end
    end

    // Retirements compared in program order
    always @(posedge clk) begin
        if (!rst && wbValid) begin
            assert (checkedCount < retireCount) begin
                recordIdx = progLen + 2 + 2 * checkedCount;
                expRd     = testData[recordIdx][4:0];
                expData   = testData[recordIdx + 1];
                assert (wbRd == expRd && wbData == expData) begin
                    checkedCount = checkedCount + 1;
                end else begin
                    $display("ERROR %0t ns: retirement %0d wrote x%0d = %h, expected x%0d = %h",
                             $time, checkedCount, wbRd, wbData, expRd, expData);
                    $display("Some tests failed");
                    $fatal(1, "Retirement mismatch");
                end
            end else begin
                $display("Unexpected retirement of x%0d at %0t ns after all %0d records",
                         wbRd, $time, retireCount);
                $display("Some tests failed");
                $fatal(1, "Extra retirement");
            end
        end
    end

    initial begin
        rst          = 1'b1;
        checkedCount = 0;
        $readmemh("testbench/pipeCore_testdata.txt", testData);
        progLen      = testData[0];
        retireCount  = testData[progLen + 1];
        repeat (3) @(negedge clk);
        rst = 1'b0;
        wait (checkedCount == retireCount);
        repeat (20) @(negedge clk);  // Quiet tail, nothing more may retire
        $display("All tests passed");
        $finish;
    end

    // Bound by program and record length plus drain margin
    initial begin
        @(negedge rst);
        #((progLen + retireCount + 50) * 10);
        $display("Timed out with %0d of %0d retirements seen", checkedCount, retireCount);
        $display("Some tests failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== rvPipe.f ====
source/pipePkg.sv
source/pipeRegs.sv
source/decodeStage.sv
source/executeStage.sv
source/dataMemory.sv
source/pipeCore.sv
testbench/pipeCore_checker.sv
testbench/pipeCore_tb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the rvPipe testbench with Verilator, exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipeCoreTb -f rvPipe.f -o pipeCoreSim &&
./obj_dir/pipeCoreSim || { echo "rvPipe simulation failed"; exit 1; }

// ==== testbench/pipeCore_testdata.txt ====
// Word 0 is the program length P, then P instruction words
// Then the retirement count R, then R pairs of rd and expected data
19
00500093 FFD00113 123451B7 00C00213 004082B3
40128333 002373B3 0013E433 006444B3 00112533
0020A5B3 00950633 00302823 01002683 00168733
00E02A23 01402783 00178463 00700813 00620663
00100893 00200913 00380993 00900013 00100A33
12
01 00000005  02 FFFFFFFD  03 12345000
04 0000000C  05 00000011  06 0000000C
07 0000000C  08 0000000D  09 00000001
0A 00000001  0B 00000000  0C 00000002
0D 12345000  0E 12345005  0F 12345005
10 00000007  13 0000000A  14 00000005
